// ==== ica_types_pkg.sv ====
package ica_types_pkg;

    localparam int ICA_WIDTH = 26;
    localparam int ICA_FRAC = 22;

    typedef logic signed [ICA_WIDTH-1:0] ica_word_t;

    typedef struct packed {
        ica_word_t ch0;
        ica_word_t ch1;
        ica_word_t ch2;
        ica_word_t ch3;
    } ica_sample_t;

    typedef struct packed {
        ica_sample_t r0;
        ica_sample_t r1;
        ica_sample_t r2;
        ica_sample_t r3;
    } ica_matrix_t;

    localparam ica_word_t ICA_MAX = {1'b0, {(ICA_WIDTH-1){1'b1}}};
    localparam ica_word_t ICA_MIN = {1'b1, {(ICA_WIDTH-1){1'b0}}};

    // -3.0 in Q3.22, used for the 3w term of the update rule.
    localparam ica_word_t ICA_NEG_THREE = ica_word_t'(-(3 <<< ICA_FRAC));

    // clamps a wide signed value into the word range.
    function automatic ica_word_t sat_word(input logic signed [63:0] v);
        if (v > 64'(ICA_MAX)) begin
            return ICA_MAX;
        end else if (v < 64'(ICA_MIN)) begin
            return ICA_MIN;
        end
        return ica_word_t'(v[ICA_WIDTH-1:0]);
    endfunction

    function automatic ica_word_t sat_add(input ica_word_t a, input ica_word_t b);
        logic signed [ICA_WIDTH:0] s;
        s = a + b;
        return sat_word(s);
    endfunction

    function automatic ica_word_t fx_mul(input ica_word_t a, input ica_word_t b);
        logic signed [2*ICA_WIDTH-1:0] prod;
        prod = a * b;
        return sat_word(prod >>> ICA_FRAC);
    endfunction

    // dot product of one row with a sample, summed in channel order ch0 to ch3.
    function automatic ica_word_t fx_dot(input ica_sample_t w, input ica_sample_t z);
        ica_word_t s;
        s = fx_mul(w.ch0, z.ch0);
        s = sat_add(s, fx_mul(w.ch1, z.ch1));
        s = sat_add(s, fx_mul(w.ch2, z.ch2));
        s = sat_add(s, fx_mul(w.ch3, z.ch3));
        return s;
    endfunction

endpackage

// ==== ica_ctrl_pkg.sv ====
package ica_ctrl_pkg;

    import ica_types_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ACCUM,
        UPDATE,
        CHECK,
        STREAM,
        DONE
    } ica_phase_t;

    localparam int ICA_DEPTH = 128;
    localparam int ICA_ADDR_W = 7;
    localparam int ICA_MAX_ITER = 8;

    // 1/1024 in Q3.22.
    localparam ica_word_t ICA_TOL = ica_word_t'(1 << (ICA_FRAC - 10));

endpackage

// ==== ica_controller.sv ====
`timescale 1ns/10ps

module ica_controller
    import ica_ctrl_pkg::*;
(
    input  logic                  clk_fast,
    input  logic                  en_mul1,
    input  logic                  start,
    input  logic                  sample_valid,
    input  logic                  within_tol,
    output logic                  wr_en,
    output logic                  load_w,
    output logic                  acc_clear,
    output logic                  acc_en,
    output logic                  upd_en,
    output logic                  chk_en,
    output logic                  proj_en,
    output logic                  busy,
    output logic                  out_last,
    output logic                  done,
    output logic                  converged,
    output logic [ICA_ADDR_W-1:0] rd_addr,
    output logic [3:0]            iter_count
);

    ica_phase_t          state;
    logic [ICA_ADDR_W:0] cnt;
    logic [3:0]          iter_next;
    logic                rd_accum;
    logic                rd_stream;
    logic                finish;

    // the low bits of the counter address the buffer for load, pass and stream.
    // the top bit covers the drain cycles after the last read.
    assign rd_addr = cnt[ICA_ADDR_W-1:0];
    assign rd_accum = (state == ACCUM) && !cnt[ICA_ADDR_W];
    assign rd_stream = (state == STREAM) && !cnt[ICA_ADDR_W];

    assign iter_next = iter_count + 4'd1;
    assign finish = within_tol || (iter_next == 4'(ICA_MAX_ITER));

    assign wr_en = (state == LOAD) && sample_valid;
    assign load_w = (state == IDLE) && start;
    assign acc_clear = (state == ACCUM) && (cnt == '0);
    assign upd_en = (state == UPDATE);
    assign chk_en = (state == CHECK);
    assign busy = (state != IDLE) && (state != DONE);
    assign done = (state == DONE);

    // read data arrives one cycle after the address, so the enables follow it.
    always_ff @(posedge clk_fast or negedge en_mul1) begin
        if (!en_mul1) begin
            acc_en <= 1'b0;
            proj_en <= 1'b0;
            out_last <= 1'b0;
        end else begin
            acc_en <= rd_accum;
            proj_en <= rd_stream;
            out_last <= (state == STREAM) && (cnt == ICA_DEPTH);
        end
    end

    always_ff @(posedge clk_fast or negedge en_mul1) begin
        if (!en_mul1) begin
            state <= IDLE;
            cnt <= '0;
            iter_count <= '0;
            converged <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= LOAD;
                        cnt <= '0;
                        iter_count <= '0;
                        converged <= 1'b0;
                    end
                end
                LOAD: begin
                    if (sample_valid) begin
                        if (cnt == ICA_DEPTH - 1) begin
                            state <= ACCUM;
                            cnt <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                // 128 reads and one drain cycle.
                ACCUM: begin
                    if (cnt == ICA_DEPTH) begin
                        state <= UPDATE;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                UPDATE: begin
                    state <= CHECK;
                end
                CHECK: begin
                    iter_count <= iter_next;
                    if (finish) begin
                        state <= STREAM;
                        converged <= within_tol;
                    end else begin
                        state <= ACCUM;
                    end
                end
                // 128 reads, then the buffer and the output register drain.
                STREAM: begin
                    if (cnt == ICA_DEPTH + 1) begin
                        state <= DONE;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== sample_buffer.sv ====
`timescale 1ns/10ps

module sample_buffer
    import ica_types_pkg::*, ica_ctrl_pkg::*;
(
    input  logic                  clk_fast,
    input  logic                  wr_en,
    input  logic [ICA_ADDR_W-1:0] wr_addr,
    input  logic [ICA_ADDR_W-1:0] rd_addr,
    input  ica_sample_t           wr_data,
    output ica_sample_t           rd_data
);

    ica_sample_t mem [ICA_DEPTH];

    always_ff @(posedge clk_fast) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle of latency.
    always_ff @(posedge clk_fast) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== weight_update.sv ====
`timescale 1ns/10ps

module weight_update
    import ica_types_pkg::*;
(
    input  logic        clk_fast,
    input  logic        en_mul1,
    input  logic        load_w,
    input  logic        acc_clear,
    input  logic        acc_en,
    input  logic        upd_en,
    input  ica_matrix_t w_init,
    input  ica_sample_t z,
    output ica_matrix_t w_cur
);

    // 128 sums of 26-bit terms need 7 more bits, one spare.
    localparam int ACC_W = ICA_WIDTH + 8;

    typedef logic signed [ACC_W-1:0] acc_t;

    ica_sample_t [3:0]      w_rows;
    ica_word_t [3:0][3:0]   w_a;
    ica_word_t [3:0]        z_a;
    ica_word_t [3:0]        g;
    ica_word_t [3:0][3:0]   w_new;
    acc_t [3:0][3:0]        acc;

    assign w_rows = w_cur;
    assign w_a = w_cur;
    assign z_a = z;

    always_comb begin
        ica_word_t p;
        ica_word_t p2;
        for (int i = 0; i < 4; i++) begin
            p = fx_dot(w_rows[i], z);
            p2 = fx_mul(p, p);
            g[i] = fx_mul(p2, p);
            // mean over the buffer minus 3w.
            for (int k = 0; k < 4; k++) begin
                w_new[i][k] = sat_add(sat_word(acc[i][k] >>> 7),
                                      fx_mul(w_a[i][k], ICA_NEG_THREE));
            end
        end
    end

    always_ff @(posedge clk_fast or negedge en_mul1) begin
        if (!en_mul1) begin
            w_cur <= '0;
            acc <= '0;
        end else begin
            if (load_w) begin
                w_cur <= w_init;
            end else if (upd_en) begin
                w_cur <= w_new;
            end
            if (acc_clear) begin
                acc <= '0;
            end else if (acc_en) begin
                for (int i = 0; i < 4; i++) begin
                    for (int k = 0; k < 4; k++) begin
                        acc[i][k] <= acc[i][k] + acc_t'(fx_mul(g[i], z_a[k]));
                    end
                end
            end
        end
    end

endmodule

// ==== convergence_check.sv ====
`timescale 1ns/10ps

module convergence_check
    import ica_types_pkg::*, ica_ctrl_pkg::*;
(
    input  logic        clk_fast,
    input  logic        en_mul1,
    input  logic        load_w,
    input  logic        chk_en,
    input  ica_matrix_t w_cur,
    output logic        within_tol
);

    ica_matrix_t        w_prev;
    logic               load_q;
    ica_word_t [15:0]   cur_a;
    ica_word_t [15:0]   prev_a;
    logic [ICA_WIDTH:0] max_diff;

    assign cur_a = w_cur;
    assign prev_a = w_prev;

    always_comb begin
        logic signed [ICA_WIDTH:0] d;
        logic [ICA_WIDTH:0]        mag;
        max_diff = '0;
        for (int e = 0; e < 16; e++) begin
            d = cur_a[e] - prev_a[e];
            mag = d[ICA_WIDTH] ? -d : d;
            if (mag > max_diff) begin
                max_diff = mag;
            end
        end
    end

    assign within_tol = (max_diff <= {1'b0, ICA_TOL});

    // w_cur holds the initial matrix one cycle after load_w.
    always_ff @(posedge clk_fast or negedge en_mul1) begin
        if (!en_mul1) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load_w;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (load_q || chk_en) begin
            w_prev <= w_cur;
        end
    end

endmodule

// ==== source_projector.sv ====
`timescale 1ns/10ps

module source_projector
    import ica_types_pkg::*;
(
    input  logic        clk_fast,
    input  logic        en_mul1,
    input  logic        proj_en,
    input  ica_matrix_t w,
    input  ica_sample_t z,
    output ica_sample_t y,
    output logic        out_valid
);

    ica_sample_t y_next;

    // each source is one row of W applied to the sample.
    always_comb begin
        y_next.ch0 = fx_dot(w.r0, z);
        y_next.ch1 = fx_dot(w.r1, z);
        y_next.ch2 = fx_dot(w.r2, z);
        y_next.ch3 = fx_dot(w.r3, z);
    end

    always_ff @(posedge clk_fast) begin
        if (proj_en) begin
            y <= y_next;
        end
    end

    always_ff @(posedge clk_fast or negedge en_mul1) begin
        if (!en_mul1) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= proj_en;
        end
    end

endmodule

// ==== fastica_core.sv ====
`timescale 1ns/10ps

module fastica_core
    import ica_types_pkg::*, ica_ctrl_pkg::*;
(
    input  logic        clk_fast,
    input  logic        en_mul1,
    input  logic        start,
    input  ica_matrix_t w_init,
    input  logic        sample_valid,
    input  ica_sample_t sample,
    output logic        busy,
    output logic        out_valid,
    output logic        out_last,
    output ica_sample_t y,
    output ica_matrix_t w_final,
    output logic        converged,
    output logic [3:0]  iter_count,
    output logic        done
);

    logic                  wr_en;
    logic                  load_w;
    logic                  acc_clear;
    logic                  acc_en;
    logic                  upd_en;
    logic                  chk_en;
    logic                  proj_en;
    logic                  within_tol;
    logic [ICA_ADDR_W-1:0] rd_addr;
    ica_sample_t           rd_data;
    ica_matrix_t           w_cur;

    assign w_final = w_cur;

    ica_controller u_ica_controller (
        .clk_fast     (clk_fast),
        .en_mul1      (en_mul1),
        .start        (start),
        .sample_valid (sample_valid),
        .within_tol   (within_tol),
        .wr_en        (wr_en),
        .load_w       (load_w),
        .acc_clear    (acc_clear),
        .acc_en       (acc_en),
        .upd_en       (upd_en),
        .chk_en       (chk_en),
        .proj_en      (proj_en),
        .busy         (busy),
        .out_last     (out_last),
        .done         (done),
        .converged    (converged),
        .rd_addr      (rd_addr),
        .iter_count   (iter_count)
    );

    // the load count doubles as the write address.
    sample_buffer u_sample_buffer (
        .clk_fast (clk_fast),
        .wr_en    (wr_en),
        .wr_addr  (rd_addr),
        .rd_addr  (rd_addr),
        .wr_data  (sample),
        .rd_data  (rd_data)
    );

    weight_update u_weight_update (
        .clk_fast  (clk_fast),
        .en_mul1   (en_mul1),
        .load_w    (load_w),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .upd_en    (upd_en),
        .w_init    (w_init),
        .z         (rd_data),
        .w_cur     (w_cur)
    );

    convergence_check u_convergence_check (
        .clk_fast   (clk_fast),
        .en_mul1    (en_mul1),
        .load_w     (load_w),
        .chk_en     (chk_en),
        .w_cur      (w_cur),
        .within_tol (within_tol)
    );

    source_projector u_source_projector (
        .clk_fast  (clk_fast),
        .en_mul1   (en_mul1),
        .proj_en   (proj_en),
        .w         (w_cur),
        .z         (rd_data),
        .y         (y),
        .out_valid (out_valid)
    );

endmodule

// ==== fastica_assert.sv ====
`timescale 1ns/10ps

module fastica_assert
    import ica_ctrl_pkg::*;
(
    input logic       clk_fast,
    input logic       en_mul1,
    input logic       start,
    input logic       busy,
    input logic       done,
    input logic       proj_en,
    input logic       out_last,
    input logic [3:0] iter_count
);

    int fail_count = 0;

    // busy only rises from a start pulse in the cycle before.
    busy_from_start: assert property (@(posedge clk_fast) disable iff (!en_mul1)
        $rose(busy) |-> $past(start))
    else begin
        $error("busy rose without a start pulse");
        fail_count++;
    end

    done_one_cycle: assert property (@(posedge clk_fast) disable iff (!en_mul1)
        done |=> !done)
    else begin
        $error("done was high for more than one cycle");
        fail_count++;
    end

    // out_last comes with the output of the final projection cycle.
    last_after_proj: assert property (@(posedge clk_fast) disable iff (!en_mul1)
        out_last |-> $past(proj_en))
    else begin
        $error("out_last without a projection in the cycle before");
        fail_count++;
    end

    iter_in_range: assert property (@(posedge clk_fast) disable iff (!en_mul1)
        iter_count <= 4'(ICA_MAX_ITER))
    else begin
        $error("iter_count went past the pass limit");
        fail_count++;
    end

endmodule

bind ica_controller fastica_assert u_fastica_assert (
    .clk_fast   (clk_fast),
    .en_mul1    (en_mul1),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .proj_en    (proj_en),
    .out_last   (out_last),
    .iter_count (iter_count)
);

// ==== tb_fastica_core.sv ====
`timescale 1ns/10ps

module tb_fastica_core
    import ica_types_pkg::*, ica_ctrl_pkg::*;
();

    localparam int RUN_LIMIT = 2000;
    localparam int DONE_LIMIT = 8;
    localparam int NUM_CASES = 4;

    // each test case holds the start matrix, the sample magnitude as a right shift
    // of a 32-bit random word, and whether the run is meant to converge.
    typedef struct packed {
        ica_matrix_t w0;
        logic [4:0]  shift;
        logic        conv;
    } case_t;

    logic        clk_fast = 1'b0;
    logic        en_mul1;
    logic        start;
    ica_matrix_t w_init;
    logic        sample_valid;
    ica_sample_t sample;
    logic        busy;
    logic        out_valid;
    logic        out_last;
    ica_sample_t y;
    ica_matrix_t w_final;
    logic        converged;
    logic [3:0]  iter_count;
    logic        done;

    integer      seed = 32'hb4d0_ec22;
    case_t       cases [NUM_CASES];
    ica_sample_t zbuf [ICA_DEPTH];

    always #2 clk_fast = ~clk_fast;

    fastica_core u_fastica_core (
        .clk_fast     (clk_fast),
        .en_mul1      (en_mul1),
        .start        (start),
        .w_init       (w_init),
        .sample_valid (sample_valid),
        .sample       (sample),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .y            (y),
        .w_final      (w_final),
        .converged    (converged),
        .iter_count   (iter_count),
        .done         (done)
    );

    task automatic next_cycle();
        @(posedge clk_fast);
        #1;
    endtask

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    always @(posedge clk_fast) begin
        if (u_fastica_core.u_ica_controller.u_fastica_assert.fail_count != 0) begin
            $display("Controller assertions reported violations");
            abort_run();
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sample(input string name, input ica_sample_t got,
                                input ica_sample_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_matrix(input string name, input ica_matrix_t got,
                                input ica_matrix_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input logic conv_exp, input logic [3:0] iter_exp);
        if (converged !== conv_exp) begin
            $display("Error: converged got %h expected %h", converged, conv_exp);
            abort_run();
        end
        if (iter_count !== iter_exp) begin
            $display("Error: iter_count got %h expected %h", iter_count, iter_exp);
            abort_run();
        end
    endtask

    function automatic ica_matrix_t diag(input ica_word_t d);
        ica_word_t [3:0][3:0] m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            m[i][i] = d;
        end
        return m;
    endfunction

    function automatic ica_word_t clamp_word(input longint v);
        if (v > longint'(ICA_MAX)) begin
            return ICA_MAX;
        end else if (v < longint'(ICA_MIN)) begin
            return ICA_MIN;
        end
        return ica_word_t'(v);
    endfunction

    // the sum saturates after every product and starts with ch0 at the top index.
    function automatic ica_word_t row_dot(input ica_word_t [3:0] w, input ica_word_t [3:0] z);
        ica_word_t s;
        s = '0;
        for (int k = 3; k >= 0; k--) begin
            s = sat_add(s, fx_mul(w[k], z[k]));
        end
        return s;
    endfunction

    function automatic ica_sample_t project(input ica_matrix_t w, input ica_sample_t z);
        ica_word_t [3:0][3:0] wa;
        ica_word_t [3:0]      ya;
        wa = w;
        for (int i = 0; i < 4; i++) begin
            ya[i] = row_dot(wa[i], z);
        end
        return ya;
    endfunction

    // repeats the update passes and the tolerance test on the buffered samples.
    task automatic run_model(input ica_matrix_t w0, output ica_matrix_t w_out,
                             output logic conv, output logic [3:0] iters);
        ica_word_t [3:0][3:0] wa;
        ica_word_t [3:0][3:0] wn;
        ica_word_t [3:0]      za;
        ica_word_t [3:0]      g;
        ica_word_t            p;
        longint               acc [4][4];
        longint               diff;
        longint               max_diff;
        wa = w0;
        iters = '0;
        conv = 1'b0;
        while (!conv && iters != 4'(ICA_MAX_ITER)) begin
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 4; k++) begin
                    acc[i][k] = 0;
                end
            end
            for (int n = 0; n < ICA_DEPTH; n++) begin
                za = zbuf[n];
                for (int i = 0; i < 4; i++) begin
                    p = row_dot(wa[i], za);
                    g[i] = fx_mul(fx_mul(p, p), p);
                    for (int k = 0; k < 4; k++) begin
                        acc[i][k] += longint'(fx_mul(g[i], za[k]));
                    end
                end
            end
            max_diff = 0;
            for (int i = 0; i < 4; i++) begin
                for (int k = 0; k < 4; k++) begin
                    wn[i][k] = sat_add(clamp_word(acc[i][k] >>> 7),
                                       fx_mul(wa[i][k], ICA_NEG_THREE));
                    diff = longint'(wn[i][k]) - longint'(wa[i][k]);
                    if (diff < 0) begin
                        diff = -diff;
                    end
                    if (diff > max_diff) begin
                        max_diff = diff;
                    end
                end
            end
            conv = (max_diff <= longint'(ICA_TOL));
            iters = iters + 4'd1;
            wa = wn;
        end
        w_out = wa;
    endtask

    initial begin
        case_t           cur;
        ica_word_t [3:0] za;
        ica_matrix_t     exp_w;
        logic            exp_conv;
        logic [3:0]      exp_iter;
        integer          r;
        int              cycles;

        en_mul1 = 1'b0;
        start = 1'b0;
        w_init = '0;
        sample_valid = 1'b0;
        sample = '0;

        // a zero matrix and a tiny diagonal settle in one pass while the others
        // keep growing by -3w and hit the pass limit.
        cases[0] = '{w0: '0, shift: 5'd12, conv: 1'b1};
        cases[1] = '{w0: diag(26'sd256), shift: 5'd9, conv: 1'b1};
        cases[2] = '{w0: diag(26'sd1 <<< 20), shift: 5'd12, conv: 1'b0};
        cases[3] = '{w0: diag(26'sd1 <<< 22), shift: 5'd7, conv: 1'b0};

        repeat (10) next_cycle();
        en_mul1 = 1'b1;
        next_cycle();
        check_bit("busy", busy, 1'b0);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("done", done, 1'b0);
        check_status(1'b0, 4'd0);

        for (int c = 0; c < NUM_CASES; c++) begin
            cur = cases[c];
            for (int n = 0; n < ICA_DEPTH; n++) begin
                for (int ch = 0; ch < 4; ch++) begin
                    r = $random(seed);
                    za[ch] = ica_word_t'(r >>> cur.shift);
                end
                zbuf[n] = za;
            end
            run_model(cur.w0, exp_w, exp_conv, exp_iter);
            if (exp_conv !== cur.conv) begin
                $display("Case %0d does not behave as the case table intends", c);
                abort_run();
            end

            w_init = cur.w0;
            start = 1'b1;
            next_cycle();
            start = 1'b0;
            check_bit("busy", busy, 1'b1);
            for (int n = 0; n < ICA_DEPTH; n++) begin
                sample = zbuf[n];
                sample_valid = 1'b1;
                next_cycle();
            end

            // a few cycles of stray start and sample strobes while busy.
            cycles = 0;
            while (!out_valid) begin
                start = (cycles < 4);
                sample_valid = (cycles < 4);
                sample = ~zbuf[cycles % ICA_DEPTH];
                w_init = ~cur.w0;
                next_cycle();
                cycles++;
                if (cycles > RUN_LIMIT) begin
                    $display("Timeout: no output stream after %0d cycles", RUN_LIMIT);
                    abort_run();
                end
            end
            start = 1'b0;
            sample_valid = 1'b0;

            for (int n = 0; n < ICA_DEPTH; n++) begin
                if (!out_valid) begin
                    $display("The output stream stopped after %0d samples", n);
                    abort_run();
                end
                check_sample("y", y, project(exp_w, zbuf[n]));
                check_bit("out_last", out_last, n == ICA_DEPTH - 1);
                next_cycle();
            end
            check_bit("out_valid", out_valid, 1'b0);

            cycles = 0;
            while (!done) begin
                next_cycle();
                cycles++;
                if (cycles > DONE_LIMIT) begin
                    $display("Timeout: done did not pulse after the last output");
                    abort_run();
                end
            end
            check_bit("busy", busy, 1'b0);
            check_status(exp_conv, exp_iter);
            check_matrix("w_final", w_final, exp_w);
            next_cycle();
            check_bit("done", done, 1'b0);
        end

        if (u_fastica_core.u_ica_controller.u_fastica_assert.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Controller assertions reported violations");
            abort_run();
        end
    end

endmodule

// ==== flist.f ====
ica_types_pkg.sv
ica_ctrl_pkg.sv
ica_controller.sv
sample_buffer.sv
weight_update.sv
convergence_check.sv
source_projector.sv
fastica_core.sv
fastica_assert.sv
tb_fastica_core.sv
